/* src/phy_mgmt_consts.svh */
`ifndef PHY_MGMT_CONSTS_SVH
`define PHY_MGMT_CONSTS_SVH

////////////////////////////////////////////////////////////
// mdio frame fields
////////////////////////////////////////////////////////////
`define MDIO_PREAMBLE_BITS 32    // ones ahead of every frame
`define MDIO_CMD_BITS      14    // start, op, phy addr, reg addr
`define MDIO_TA_BITS       2
`define MDIO_DATA_BITS     16
`define MDIO_PHY_ADDR      5'd0

// phy bring-up
`define MDIO_NUM_REGS      32
`define MDIO_POST_RST_WAIT 64    // short settle, fine for simulation
`define MDIO_LOOPBACK_BIT  14    // control register 0.14

////////////////////////////////////////////////////////////
// memory dump layout
////////////////////////////////////////////////////////////
`define DUMP_BASE_ADDR     13'h400
`define DUMP_DELIMITER     32'hAAAA_AAAA
`define DUMP_RECORD_TAG    4'hB

`endif

/* src/mdio_pkg.sv */
package mdio_pkg;

    // clause 22 opcodes, sent msb first after the start bits
    typedef enum logic [1:0] {
        MDIO_OP_WRITE = 2'b01,
        MDIO_OP_READ  = 2'b10
    } mdio_op_e;

    // phy register number
    typedef logic [4:0] mdio_reg_addr_t;

    // one 16 bit phy register value
    typedef logic [15:0] mdio_data_t;

endpackage

/* src/dump_pkg.sv */
package dump_pkg;

    // one tagged record word in the dump
    typedef struct packed {
        logic [3:0]              tag;     // record marker nibble
        logic [2:0]              zero_hi;
        mdio_pkg::mdio_reg_addr_t reg_num;
        logic [3:0]              zero_lo;
        mdio_pkg::mdio_data_t    data;
    } dump_record_s;

    // delimiters go out raw, records through the field view
    typedef union packed {
        logic [31:0]  raw;
        dump_record_s rec;
    } dump_word_u;

    typedef logic [12:0] wb_addr_t;   // word address

endpackage

/* src/mdio_frame_engine.sv */
`timescale 1ns/1ps
`include "phy_mgmt_consts.svh"

module mdio_frame_engine
    import mdio_pkg::*;
(
    input  logic           enet_mdc_clk,
    input  logic           CPU_RESETn,
    input  logic           frame_start,
    input  mdio_op_e       frame_op,
    input  mdio_reg_addr_t frame_reg,
    input  mdio_data_t     frame_wr_data,
    input  logic           mdio_i,
    output logic           mdio_o,
    output logic           mdio_oe,
    output mdio_data_t     frame_rd_data,
    output logic           frame_done
);

    localparam logic [2:0] PH_IDLE = 3'd0,
                           PH_PRE  = 3'd1,
                           PH_CMD  = 3'd2,
                           PH_TA   = 3'd3,
                           PH_DATA = 3'd4;

    logic [2:0]  phase;
    logic [4:0]  bit_cnt;      // bits left in the current phase, minus one
    logic        is_read;
    logic        shift_en;
    logic [31:0] tx_sr;        // command, turnaround and write data
    mdio_data_t  rx_sr;

    // next bit leaves the shifter on the last preamble cycle and after
    assign shift_en = (phase == PH_PRE && bit_cnt == 5'd0) || phase == PH_CMD ||
                      phase == PH_TA || phase == PH_DATA;

    assign frame_rd_data = rx_sr;

    ////////////////////////////////////////////////////////////
    // phase fsm
    ////////////////////////////////////////////////////////////
    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            phase      <= PH_IDLE;
            bit_cnt    <= '0;
            is_read    <= 1'b0;
            mdio_oe    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (frame_start) begin
                        phase   <= PH_PRE;
                        bit_cnt <= 5'(`MDIO_PREAMBLE_BITS - 1);
                        is_read <= (frame_op == MDIO_OP_READ);
                        mdio_oe <= 1'b1;
                    end
                end
                PH_PRE: begin
                    if (bit_cnt == 5'd0) begin
                        phase   <= PH_CMD;
                        bit_cnt <= 5'(`MDIO_CMD_BITS - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                PH_CMD: begin
                    if (bit_cnt == 5'd0) begin
                        phase   <= PH_TA;
                        bit_cnt <= 5'(`MDIO_TA_BITS - 1);
                        if (is_read) begin
                            mdio_oe <= 1'b0;   // phy owns the line from here
                        end
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                PH_TA: begin
                    if (bit_cnt == 5'd0) begin
                        phase   <= PH_DATA;
                        bit_cnt <= 5'(`MDIO_DATA_BITS - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                PH_DATA: begin
                    if (bit_cnt == 5'd0) begin
                        phase      <= PH_IDLE;
                        mdio_oe    <= 1'b0;
                        frame_done <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt - 5'd1;
                    end
                end
                default: phase <= PH_IDLE;
            endcase
        end
    end

    // serial data path
    always_ff @(posedge enet_mdc_clk) begin
        if (phase == PH_IDLE && frame_start) begin
            tx_sr  <= {2'b01, frame_op, `MDIO_PHY_ADDR, frame_reg, 2'b10, frame_wr_data};
            mdio_o <= 1'b1;                          // preamble
        end else if (shift_en) begin
            mdio_o <= tx_sr[31];
            tx_sr  <= {tx_sr[30:0], 1'b0};
        end
        if (phase == PH_DATA && is_read) begin
            rx_sr <= {rx_sr[14:0], mdio_i};          // msb arrives first
        end
    end

endmodule

/* src/phy_mgmt_seq.sv */
`timescale 1ns/1ps
`include "phy_mgmt_consts.svh"

module phy_mgmt_seq
    import mdio_pkg::*;
(
    input  logic           enet_mdc_clk,
    input  logic           CPU_RESETn,
    output logic           frame_start,
    output mdio_op_e       frame_op,
    output mdio_reg_addr_t frame_reg,
    output mdio_data_t     frame_wr_data,
    input  logic           frame_done,
    input  mdio_data_t     frame_rd_data,
    output logic           bank_we,
    output mdio_reg_addr_t bank_waddr,
    output mdio_data_t     bank_wdata,
    input  mdio_data_t     reg0_value,
    output logic           dump_start,
    input  logic           dump_done,
    output logic           loopback_set
);

    localparam logic [2:0] S_SETTLE    = 3'd0,
                           S_RD_START  = 3'd1,
                           S_RD_WAIT   = 3'd2,
                           S_DUMP      = 3'd3,
                           S_DUMP_WAIT = 3'd4,
                           S_WR_START  = 3'd5,
                           S_WR_WAIT   = 3'd6,
                           S_DONE      = 3'd7;

    logic [2:0]     state;
    logic [6:0]     settle_cnt;
    mdio_reg_addr_t reg_idx;
    logic           in_write;

    assign in_write    = (state == S_WR_START) || (state == S_WR_WAIT);
    assign frame_start = (state == S_RD_START) || (state == S_WR_START);
    assign frame_op    = in_write ? MDIO_OP_WRITE : MDIO_OP_READ;
    assign frame_reg   = in_write ? '0 : reg_idx;   // the write always targets reg 0
    assign dump_start  = (state == S_DUMP);

    always_comb begin
        frame_wr_data = reg0_value;
        frame_wr_data[`MDIO_LOOPBACK_BIT] = 1'b1;
    end

    // capture into the bank as the read frame finishes
    assign bank_we    = (state == S_RD_WAIT) && frame_done;
    assign bank_waddr = reg_idx;
    assign bank_wdata = frame_rd_data;

    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            state        <= S_SETTLE;
            settle_cnt   <= '0;
            reg_idx      <= '0;
            loopback_set <= 1'b0;
        end else begin
            case (state)
                S_SETTLE: begin
                    settle_cnt <= settle_cnt + 7'd1;
                    if (settle_cnt == 7'(`MDIO_POST_RST_WAIT - 1)) state <= S_RD_START;
                end
                S_RD_START: state <= S_RD_WAIT;
                S_RD_WAIT: begin
                    if (frame_done) begin
                        if (reg_idx == 5'(`MDIO_NUM_REGS - 1)) begin
                            state <= S_DUMP;
                        end else begin
                            reg_idx <= reg_idx + 5'd1;
                            state   <= S_RD_START;
                        end
                    end
                end
                S_DUMP:      state <= S_DUMP_WAIT;
                S_DUMP_WAIT: if (dump_done) state <= S_WR_START;
                S_WR_START:  state <= S_WR_WAIT;
                S_WR_WAIT: begin
                    if (frame_done) begin
                        state        <= S_DONE;
                        loopback_set <= 1'b1;
                    end
                end
                default: state <= S_DONE;   // parked, mdio released
            endcase
        end
    end

endmodule

/* src/phy_reg_bank.sv */
`timescale 1ns/1ps
`include "phy_mgmt_consts.svh"

module phy_reg_bank
    import mdio_pkg::*;
(
    input  logic           enet_mdc_clk,
    input  logic           CPU_RESETn,
    input  logic           bank_we,
    input  mdio_reg_addr_t bank_waddr,
    input  mdio_data_t     bank_wdata,
    input  mdio_reg_addr_t bank_raddr,
    output mdio_data_t     bank_rdata,
    output mdio_data_t     reg0_value
);

    mdio_data_t regs [`MDIO_NUM_REGS];

    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            for (int i = 0; i < `MDIO_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (bank_we) begin
            regs[bank_waddr] <= bank_wdata;
        end
    end

    assign bank_rdata = regs[bank_raddr];   // dump side
    assign reg0_value = regs[0];            // control reg, source of the loopback write

endmodule

/* src/reg_dump_wb_master.sv */
`timescale 1ns/1ps
`include "phy_mgmt_consts.svh"

module reg_dump_wb_master
    import mdio_pkg::*;
    import dump_pkg::*;
(
    input  logic           enet_mdc_clk,
    input  logic           CPU_RESETn,
    input  logic           dump_start,
    output mdio_reg_addr_t bank_raddr,
    input  mdio_data_t     bank_rdata,
    output logic           wb_cyc,
    output logic           wb_stb,
    output logic           wb_we,
    output wb_addr_t       wb_adr,
    output logic [31:0]    wb_dat_w,
    input  logic           wb_ack,
    output logic           dump_done
);

    // word 0 and the last word are delimiters, records sit in between
    localparam logic [5:0] LAST_IDX = 6'(`MDIO_NUM_REGS + 1);

    logic [5:0] word_idx;
    logic [5:0] next_idx;
    logic       launch;
    logic       step;
    dump_word_u next_word;

    assign launch = dump_start && !wb_cyc && !dump_done;   // one dump per reset
    assign step   = wb_cyc && wb_ack;
    assign next_idx = word_idx + 6'd1;

    assign bank_raddr = word_idx[4:0];   // word n+1 carries register n

    always_comb begin
        next_word.raw = `DUMP_DELIMITER;
        if (next_idx != LAST_IDX) begin
            next_word.rec.tag     = `DUMP_RECORD_TAG;
            next_word.rec.zero_hi = '0;
            next_word.rec.reg_num = bank_raddr;
            next_word.rec.zero_lo = '0;
            next_word.rec.data    = bank_rdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // bus cycle control
    ////////////////////////////////////////////////////////////
    always_ff @(posedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            wb_we     <= 1'b0;
            dump_done <= 1'b0;
            word_idx  <= '0;
        end else if (launch) begin
            wb_cyc   <= 1'b1;
            wb_stb   <= 1'b1;
            wb_we    <= 1'b1;
            word_idx <= '0;
        end else if (step) begin
            if (word_idx == LAST_IDX) begin
                wb_cyc    <= 1'b0;
                wb_stb    <= 1'b0;
                wb_we     <= 1'b0;
                dump_done <= 1'b1;     // sticky until reset
            end else begin
                word_idx <= next_idx;
            end
        end
    end

    // address and data only move on launch or an accepted write
    always_ff @(posedge enet_mdc_clk) begin
        if (launch) begin
            wb_adr   <= `DUMP_BASE_ADDR;
            wb_dat_w <= `DUMP_DELIMITER;
        end else if (step && word_idx != LAST_IDX) begin
            wb_adr   <= `DUMP_BASE_ADDR + wb_addr_t'(next_idx);
            wb_dat_w <= next_word.raw;
        end
    end

endmodule

/* src/phy_mgmt_top.sv */
`timescale 1ns/1ps

module phy_mgmt_top
    import mdio_pkg::*;
    import dump_pkg::*;
(
    input  logic        enet_mdc_clk,
    input  logic        CPU_RESETn,
    inout  wire         enet_mdio,     // needs an external pull-up
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output wb_addr_t    wb_adr,
    output logic [31:0] wb_dat_w,
    input  logic        wb_ack,
    output logic        dump_done,
    output logic        loopback_set
);

    // sequencer <-> frame engine
    logic           frame_start;
    mdio_op_e       frame_op;
    mdio_reg_addr_t frame_reg;
    mdio_data_t     frame_wr_data;
    mdio_data_t     frame_rd_data;
    logic           frame_done;
    logic           mdio_o;
    logic           mdio_oe;

    // register bank ports
    logic           bank_we;
    mdio_reg_addr_t bank_waddr;
    mdio_data_t     bank_wdata;
    mdio_reg_addr_t bank_raddr;
    mdio_data_t     bank_rdata;
    mdio_data_t     reg0_value;
    logic           dump_start;

    assign enet_mdio = mdio_oe ? mdio_o : 1'bz;   // released line floats high

    mdio_frame_engine u_mdio_frame_engine (
        .enet_mdc_clk  (enet_mdc_clk),
        .CPU_RESETn    (CPU_RESETn),
        .frame_start   (frame_start),
        .frame_op      (frame_op),
        .frame_reg     (frame_reg),
        .frame_wr_data (frame_wr_data),
        .mdio_i        (enet_mdio),
        .mdio_o        (mdio_o),
        .mdio_oe       (mdio_oe),
        .frame_rd_data (frame_rd_data),
        .frame_done    (frame_done)
    );

    phy_mgmt_seq u_phy_mgmt_seq (
        .enet_mdc_clk  (enet_mdc_clk),
        .CPU_RESETn    (CPU_RESETn),
        .frame_start   (frame_start),
        .frame_op      (frame_op),
        .frame_reg     (frame_reg),
        .frame_wr_data (frame_wr_data),
        .frame_done    (frame_done),
        .frame_rd_data (frame_rd_data),
        .bank_we       (bank_we),
        .bank_waddr    (bank_waddr),
        .bank_wdata    (bank_wdata),
        .reg0_value    (reg0_value),
        .dump_start    (dump_start),
        .dump_done     (dump_done),
        .loopback_set  (loopback_set)
    );

    phy_reg_bank u_phy_reg_bank (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .bank_we      (bank_we),
        .bank_waddr   (bank_waddr),
        .bank_wdata   (bank_wdata),
        .bank_raddr   (bank_raddr),
        .bank_rdata   (bank_rdata),
        .reg0_value   (reg0_value)
    );

    reg_dump_wb_master u_reg_dump_wb_master (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .dump_start   (dump_start),
        .bank_raddr   (bank_raddr),
        .bank_rdata   (bank_rdata),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .dump_done    (dump_done)
    );

endmodule

/* verification/phy_mgmt_asserts.sv */
`timescale 1ns/1ps

module phy_mgmt_asserts (
    input logic        enet_mdc_clk,
    input logic        CPU_RESETn,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic [12:0] wb_adr,
    input logic [31:0] wb_dat_w,
    input logic        wb_ack,
    input logic        dump_done,
    input logic        mdio_oe
);

    int assert_failures = 0;   // read by the testbench at the end of the run

    stb_in_cyc: assert property (@(posedge enet_mdc_clk) disable iff (!CPU_RESETn)
        wb_stb |-> wb_cyc)
        else begin
            assert_failures++;
            $error("wb_stb high outside a bus cycle");
        end

    // classic bus holds the request until ack
    req_stable: assert property (@(posedge enet_mdc_clk) disable iff (!CPU_RESETn)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_dat_w)))
        else begin
            assert_failures++;
            $error("wb_adr or wb_dat_w moved before ack");
        end

    mdio_vs_bus: assert property (@(posedge enet_mdc_clk) disable iff (!CPU_RESETn)
        !(mdio_oe && wb_cyc))
        else begin
            assert_failures++;
            $error("mdio driven during a bus cycle");
        end

    done_vs_bus: assert property (@(posedge enet_mdc_clk) disable iff (!CPU_RESETn)
        !(dump_done && wb_cyc))
        else begin
            assert_failures++;
            $error("dump_done high during a bus cycle");
        end

endmodule

bind phy_mgmt_top phy_mgmt_asserts u_phy_mgmt_asserts (
    .enet_mdc_clk (enet_mdc_clk),
    .CPU_RESETn   (CPU_RESETn),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_ack       (wb_ack),
    .dump_done    (dump_done),
    .mdio_oe      (mdio_oe)
);

/* verification/tb_phy_mgmt.sv */
`timescale 1ns/1ps
`include "phy_mgmt_consts.svh"

module tb_phy_mgmt;

    localparam int DUMP_WORDS       = `MDIO_NUM_REGS + 2;   // delimiter, records, delimiter
    localparam int DUMP_TIMEOUT     = 5000;
    localparam int LOOPBACK_TIMEOUT = 200;

    localparam logic [2:0] P_IDLE  = 3'd0,
                           P_START = 3'd1,
                           P_CMD   = 3'd2,
                           P_READ  = 3'd3,
                           P_WRITE = 3'd4;

    logic        enet_mdc_clk = 1'b0;
    logic        CPU_RESETn;
    wire         enet_mdio;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [12:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic        wb_ack = 1'b0;
    logic        dump_done;
    logic        loopback_set;

    logic [15:0] golden [`MDIO_NUM_REGS];

    // phy model state
    logic        phy_oe  = 1'b0;
    logic        phy_o   = 1'b1;
    logic        next_oe = 1'b0;   // drive plan for the coming cycle
    logic        next_o  = 1'b1;
    logic [2:0]  phy_state = P_IDLE;
    logic [11:0] cmd_sh;           // op, phy addr, reg addr
    logic [17:0] wr_sh;            // turnaround and write data
    logic [16:0] rd_sr;
    int          ones_seen = 0;
    int          bit_cnt = 0;
    int          rd_left = 0;
    int          reads_seen = 0;
    int          writes_seen = 0;

    // wishbone slave state
    integer      seed = 32'h2605;
    int          ack_delay = -1;
    int          writes_accepted = 0;

    pullup (enet_mdio);
    assign enet_mdio = phy_oe ? phy_o : 1'bz;

    always #5 enet_mdc_clk = ~enet_mdc_clk;

    phy_mgmt_top u_phy_mgmt_top (
        .enet_mdc_clk (enet_mdc_clk),
        .CPU_RESETn   (CPU_RESETn),
        .enet_mdio    (enet_mdio),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_ack       (wb_ack),
        .dump_done    (dump_done),
        .loopback_set (loopback_set)
    );

    task automatic fail_run(input string what);
        $display("[ERROR] %s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("%s: expected 0x%0h, got 0x%0h", name, expected, actual));
        end
    endtask

    // word idx of the dump as the memory should see it
    function automatic logic [31:0] expected_dump_word(input int idx);
        logic [4:0] reg_num;
        if (idx == 0 || idx == `MDIO_NUM_REGS + 1) begin
            return `DUMP_DELIMITER;
        end
        reg_num = 5'(idx - 1);
        return {`DUMP_RECORD_TAG, 3'b000, reg_num, 4'b0000, golden[reg_num]};
    endfunction

    ////////////////////////////////////////////////////////////
    // phy model decodes on the falling edge and drives after the rising edge
    ////////////////////////////////////////////////////////////
    always @(posedge enet_mdc_clk) begin
        #1;
        phy_oe = next_oe;
        phy_o  = next_o;
    end

    always @(negedge enet_mdc_clk) begin
        if (!CPU_RESETn) begin
            phy_state = P_IDLE;
            ones_seen = 0;
            next_oe   = 1'b0;
        end else begin
            case (phy_state)
                P_IDLE: begin
                    if (enet_mdio === 1'b1) begin
                        if (ones_seen < 64) ones_seen++;
                    end else begin
                        if (ones_seen < `MDIO_PREAMBLE_BITS) begin
                            fail_run("MDIO start bit came after a short preamble");
                        end
                        phy_state = P_START;
                    end
                end
                P_START: begin
                    if (enet_mdio !== 1'b1) begin
                        fail_run("second MDIO start bit is not 1");
                    end
                    bit_cnt   = 0;
                    phy_state = P_CMD;
                end
                P_CMD: begin
                    cmd_sh = {cmd_sh[10:0], enet_mdio};
                    bit_cnt++;
                    if (bit_cnt == 12) begin
                        check_value("mdio phy address", 32'(cmd_sh[9:5]), 32'(`MDIO_PHY_ADDR));
                        if (cmd_sh[11:10] == 2'b10) begin
                            if (reads_seen >= `MDIO_NUM_REGS) begin
                                fail_run("more than 32 MDIO read frames");
                            end
                            check_value("mdio read register", 32'(cmd_sh[4:0]), reads_seen);
                            check_value("dump_done during read", 32'(dump_done), 32'd0);
                            rd_sr     = {1'b0, golden[cmd_sh[4:0]]};   // ta 0, then data
                            rd_left   = 17;
                            next_oe   = 1'b0;      // first turnaround cycle stays released
                            reads_seen++;
                            phy_state = P_READ;
                        end else if (cmd_sh[11:10] == 2'b01) begin
                            if (writes_seen != 0) begin
                                fail_run("more than one MDIO write frame");
                            end
                            check_value("mdio write register", 32'(cmd_sh[4:0]), 32'd0);
                            check_value("dump_done before write", 32'(dump_done), 32'd1);
                            bit_cnt   = 0;
                            phy_state = P_WRITE;
                        end else begin
                            fail_run("MDIO frame carries an unknown opcode");
                        end
                    end
                end
                P_READ: begin
                    if (rd_left > 0) begin
                        next_oe = 1'b1;
                        next_o  = rd_sr[16];
                        rd_sr   = {rd_sr[15:0], 1'b0};
                        rd_left--;
                    end else begin
                        next_oe   = 1'b0;   // hand the line back
                        ones_seen = 0;
                        phy_state = P_IDLE;
                    end
                end
                P_WRITE: begin
                    wr_sh = {wr_sh[16:0], enet_mdio};
                    bit_cnt++;
                    if (bit_cnt == 18) begin
                        check_value("mdio write turnaround", 32'(wr_sh[17:16]), 32'h2);
                        check_value("mdio write data", 32'(wr_sh[15:0]),
                                    32'(golden[0] | (16'h1 << `MDIO_LOOPBACK_BIT)));
                        check_value("loopback_set during write", 32'(loopback_set), 32'd0);
                        writes_seen++;
                        ones_seen = 0;
                        phy_state = P_IDLE;
                    end
                end
                default: phy_state = P_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // wishbone slave with random ack latency
    ////////////////////////////////////////////////////////////
    always @(posedge enet_mdc_clk) begin
        #1;
        wb_ack = 1'b0;
        if (CPU_RESETn && wb_cyc && wb_stb) begin
            if (ack_delay < 0) ack_delay = $unsigned($random(seed)) % 4;   // new request
            if (ack_delay == 0) begin
                if (writes_accepted >= DUMP_WORDS) begin
                    fail_run("more than 34 Wishbone writes");
                end
                check_value("wb_we", 32'(wb_we), 32'd1);
                check_value("wb_adr", 32'(wb_adr),
                            32'(`DUMP_BASE_ADDR) + 32'(writes_accepted));
                check_value("wb_dat_w", wb_dat_w, expected_dump_word(writes_accepted));
                writes_accepted++;
                wb_ack    = 1'b1;
                ack_delay = -1;
            end else begin
                ack_delay--;
            end
        end
    end

    initial begin
        int fd;
        int cycles;
        CPU_RESETn = 1'b0;
        fd = $fopen("verification/phy_mgmt_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open verification/phy_mgmt_golden.txt");
        end
        $fclose(fd);
        $readmemh("verification/phy_mgmt_golden.txt", golden);

        repeat (2) @(posedge enet_mdc_clk);
        #1;
        CPU_RESETn = 1'b1;

        // quiet through the settle time
        repeat (`MDIO_POST_RST_WAIT) begin
            @(negedge enet_mdc_clk);
            check_value("wb_cyc", 32'(wb_cyc), 32'd0);
            check_value("wb_stb", 32'(wb_stb), 32'd0);
            check_value("dump_done", 32'(dump_done), 32'd0);
            check_value("loopback_set", 32'(loopback_set), 32'd0);
        end
        check_value("read frames in settle time", reads_seen, 32'd0);

        cycles = 0;
        while (dump_done !== 1'b1) begin
            @(negedge enet_mdc_clk);
            cycles++;
            if (cycles > DUMP_TIMEOUT) fail_run("timed out waiting for dump_done");
        end
        check_value("mdio read frames", reads_seen, `MDIO_NUM_REGS);
        check_value("wishbone writes", writes_accepted, DUMP_WORDS);
        check_value("wb_cyc after dump", 32'(wb_cyc), 32'd0);
        check_value("wb_stb after dump", 32'(wb_stb), 32'd0);

        cycles = 0;
        while (loopback_set !== 1'b1) begin
            @(negedge enet_mdc_clk);
            cycles++;
            if (cycles > LOOPBACK_TIMEOUT) fail_run("timed out waiting for loopback_set");
        end
        check_value("mdio write frames", writes_seen, 32'd1);

        // line released and everything parked
        repeat (16) begin
            @(negedge enet_mdc_clk);
            check_value("enet_mdio", 32'(enet_mdio), 32'd1);
            check_value("loopback_set", 32'(loopback_set), 32'd1);
            check_value("dump_done", 32'(dump_done), 32'd1);
        end
        check_value("mdio read frames", reads_seen, `MDIO_NUM_REGS);
        check_value("mdio write frames", writes_seen, 32'd1);
        check_value("wishbone writes", writes_accepted, DUMP_WORDS);

        if (u_phy_mgmt_top.u_phy_mgmt_asserts.assert_failures != 0) begin
            fail_run("a bound Wishbone or MDIO assertion failed during the run");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* verification/phy_mgmt_golden.txt */
// one 16 bit hex value per line, phy registers 0 to 31 in order
// the phy model returns line n when register n is read
1140
796D
0141
0DD1
01E1
C5E1
000F
2001
4006
0300
3C00
8A5C
1234
0000
A5A5
3000
0078
AC02
F00F
0040
0C60
7E81
0FF0
C3C3
4100
1E2D
000A
848B
3C4B
6996
9669
FFFF

/* build.f */
+incdir+src
src/mdio_pkg.sv
src/dump_pkg.sv
src/mdio_frame_engine.sv
src/phy_mgmt_seq.sv
src/phy_reg_bank.sv
src/reg_dump_wb_master.sv
src/phy_mgmt_top.sv
verification/phy_mgmt_asserts.sv
verification/tb_phy_mgmt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds and runs the phy management testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_phy_mgmt -f build.f -o tb_phy_mgmt
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_phy_mgmt > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi
echo "simulation finished without failures"
exit 0
